/* source/adder_pkg.sv */
package adder_pkg;

  // --------------------
  // Word geometry
  // --------------------

  parameter int DATA_WIDTH       = 64;
  parameter int GROUP_SIZE       = 4;                                // Bits per lookahead group
  parameter int NUM_GROUPS       = DATA_WIDTH / GROUP_SIZE;         // 16 groups
  parameter int GROUPS_PER_BLOCK = 4;                                // Groups per lookahead block
  parameter int NUM_BLOCKS       = NUM_GROUPS / GROUPS_PER_BLOCK;   // 4 blocks

  // --------------------
  // Word types
  // --------------------

  typedef logic [DATA_WIDTH-1:0] data_t;      // Operand or sum
  typedef logic [NUM_GROUPS-1:0] group_vec_t; // One flag per group

  // Propagate/generate word. The bitwise stage sees 64 flat bits,
  // the group stages see the same bits as 16 nibbles.
  typedef union packed {
    logic [DATA_WIDTH-1:0]                 flat;
    logic [NUM_GROUPS-1:0][GROUP_SIZE-1:0] groups;
  } pg_word_u;

endpackage

/* source/adder_pg_stage.sv */
`timescale 1ns/1ps

module adder_pg_stage
  import adder_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  data_t    a,
  input  data_t    b,
  output logic     pg_valid,
  output pg_word_u p,
  output pg_word_u g
);

  // --------------------
  // Valid strobe
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pg_valid <= 1'b0;
    end
    else
    begin
      pg_valid <= in_valid;
    end
  end

  // --------------------
  // Bit propagate/generate
  // --------------------

  always_ff @(posedge clk)
  begin
    p.flat <= a ^ b;  // Half sum
    g.flat <= a & b;  // Carry out of the bit itself
  end

endmodule

/* source/adder_group_stage.sv */
`timescale 1ns/1ps

module adder_group_stage
  import adder_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pg_valid,
  input  pg_word_u p,
  input  pg_word_u g,
  output logic     grp_valid,
  output pg_word_u p_fwd,
  output pg_word_u gp_local,
  output pg_word_u pp_local
);

  pg_word_u gp_next;
  pg_word_u pp_next;

  // --------------------
  // In-group prefixes
  // --------------------

  // Bit j of a group holds G/P of the span from the group's bit 0 up to j.
  always_comb
  begin
    gp_next = '0;
    pp_next = '0;
    for (int k = 0; k < NUM_GROUPS; k++)
    begin
      gp_next.groups[k][0] = g.groups[k][0];  // Lowest bit starts the span
      pp_next.groups[k][0] = p.groups[k][0];
      for (int j = 1; j < GROUP_SIZE; j++)
      begin
        gp_next.groups[k][j] = g.groups[k][j] |
                               (p.groups[k][j] & gp_next.groups[k][j-1]);
        pp_next.groups[k][j] = p.groups[k][j] & pp_next.groups[k][j-1];
      end
    end
  end

  // --------------------
  // Pipeline registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grp_valid <= 1'b0;
    end
    else
    begin
      grp_valid <= pg_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    p_fwd    <= p;        // Needed again for the sum bits
    gp_local <= gp_next;  // Top bit of each nibble is group generate
    pp_local <= pp_next;  // Top bit of each nibble is group propagate
  end

endmodule

/* source/adder_block_stage.sv */
`timescale 1ns/1ps

module adder_block_stage
  import adder_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       grp_valid,
  input  pg_word_u   p_in,
  input  pg_word_u   gp_local_in,
  input  pg_word_u   pp_local_in,
  output logic       blk_valid,
  output pg_word_u   p_fwd,
  output pg_word_u   gp_local,
  output pg_word_u   pp_local,
  output group_vec_t group_carry
);

  logic [NUM_BLOCKS-1:0][GROUPS_PER_BLOCK-1:0] blk_gp;  // Prefix G over groups in a block
  logic [NUM_BLOCKS-1:0][GROUPS_PER_BLOCK-1:0] blk_pp;  // Prefix P over groups in a block
  logic [NUM_BLOCKS-1:0]                       blk_carry;
  group_vec_t                                  carry_next;

  // --------------------
  // Block generate/propagate
  // --------------------

  always_comb
  begin
    blk_gp = '0;
    blk_pp = '0;
    for (int m = 0; m < NUM_BLOCKS; m++)
    begin
      blk_gp[m][0] = gp_local_in.groups[m*GROUPS_PER_BLOCK][GROUP_SIZE-1];
      blk_pp[m][0] = pp_local_in.groups[m*GROUPS_PER_BLOCK][GROUP_SIZE-1];
      for (int i = 1; i < GROUPS_PER_BLOCK; i++)
      begin
        blk_gp[m][i] = gp_local_in.groups[m*GROUPS_PER_BLOCK+i][GROUP_SIZE-1] |
                       (pp_local_in.groups[m*GROUPS_PER_BLOCK+i][GROUP_SIZE-1] &
                        blk_gp[m][i-1]);
        blk_pp[m][i] = pp_local_in.groups[m*GROUPS_PER_BLOCK+i][GROUP_SIZE-1] &
                       blk_pp[m][i-1];
      end
    end
  end

  // --------------------
  // Block lookahead and group carries
  // --------------------

  always_comb
  begin
    blk_carry[0] = 1'b0;  // No carry-in to the word
    for (int m = 1; m < NUM_BLOCKS; m++)
    begin
      blk_carry[m] = blk_gp[m-1][GROUPS_PER_BLOCK-1] |
                     (blk_pp[m-1][GROUPS_PER_BLOCK-1] & blk_carry[m-1]);
    end

    for (int m = 0; m < NUM_BLOCKS; m++)
    begin
      carry_next[m*GROUPS_PER_BLOCK] = blk_carry[m];  // First group takes block carry
      for (int i = 1; i < GROUPS_PER_BLOCK; i++)
      begin
        carry_next[m*GROUPS_PER_BLOCK+i] = blk_gp[m][i-1] |
                                           (blk_pp[m][i-1] & blk_carry[m]);
      end
    end
  end

  // --------------------
  // Pipeline registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      blk_valid <= 1'b0;
    end
    else
    begin
      blk_valid <= grp_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    p_fwd       <= p_in;
    gp_local    <= gp_local_in;
    pp_local    <= pp_local_in;
    group_carry <= carry_next;
  end

endmodule

/* source/adder_sum_stage.sv */
`timescale 1ns/1ps

module adder_sum_stage
  import adder_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       blk_valid,
  input  pg_word_u   p_in,
  input  pg_word_u   gp_local_in,
  input  pg_word_u   pp_local_in,
  input  group_vec_t group_carry,
  output logic       out_valid,
  output data_t      sum
);

  pg_word_u bit_carry;

  // Carry into each bit from the group carry and the in-group prefix below it
  always_comb
  begin
    bit_carry = '0;
    for (int k = 0; k < NUM_GROUPS; k++)
    begin
      bit_carry.groups[k][0] = group_carry[k];
      for (int j = 1; j < GROUP_SIZE; j++)
      begin
        bit_carry.groups[k][j] = gp_local_in.groups[k][j-1] |
                                 (pp_local_in.groups[k][j-1] & group_carry[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= blk_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    sum <= p_in.flat ^ bit_carry.flat;  // Wraps modulo 2^64
  end

endmodule

/* source/prefix_adder64.sv */
`timescale 1ns/1ps

module prefix_adder64
  import adder_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  data_t a,
  input  data_t b,
  output logic  out_valid,
  output data_t sum
);

  // --------------------
  // Stage wires
  // --------------------

  logic       pg_valid;
  pg_word_u   pg_p;
  pg_word_u   pg_g;

  logic       grp_valid;
  pg_word_u   grp_p;
  pg_word_u   grp_gp;
  pg_word_u   grp_pp;

  logic       blk_valid;
  pg_word_u   blk_p;
  pg_word_u   blk_gp;
  pg_word_u   blk_pp;
  group_vec_t blk_carry;

  // --------------------
  // Four-stage chain
  // --------------------

  adder_pg_stage adder_pg_stage_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pg_valid (pg_valid),
    .p        (pg_p),
    .g        (pg_g)
  );

  adder_group_stage adder_group_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pg_valid  (pg_valid),
    .p         (pg_p),
    .g         (pg_g),
    .grp_valid (grp_valid),
    .p_fwd     (grp_p),
    .gp_local  (grp_gp),
    .pp_local  (grp_pp)
  );

  adder_block_stage adder_block_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .grp_valid   (grp_valid),
    .p_in        (grp_p),
    .gp_local_in (grp_gp),
    .pp_local_in (grp_pp),
    .blk_valid   (blk_valid),
    .p_fwd       (blk_p),
    .gp_local    (blk_gp),
    .pp_local    (blk_pp),
    .group_carry (blk_carry)
  );

  adder_sum_stage adder_sum_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .blk_valid   (blk_valid),
    .p_in        (blk_p),
    .gp_local_in (blk_gp),
    .pp_local_in (blk_pp),
    .group_carry (blk_carry),
    .out_valid   (out_valid),
    .sum         (sum)
  );

endmodule

/* bench/prefix_adder64_properties.sv */
`timescale 1ns/1ps

module prefix_adder64_properties
  import adder_pkg::*;
#(
  parameter int LATENCY = 4
)
(
  input logic  clk,
  input logic  rst_n,
  input logic  in_valid,
  input logic  out_valid,
  input data_t sum
);

  // Output strobe is the input strobe seen through every stage
  valid_delay: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid, LATENCY)
  ) else $error("out_valid does not follow in_valid by %0d cycles", LATENCY);

  quiet_in_reset: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else $error("out_valid high while reset is held");

  known_sum: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(sum)
  ) else $error("sum has unknown bits while out_valid is high");

endmodule

bind prefix_adder64 prefix_adder64_properties #(
  .LATENCY (4)
) prefix_adder64_properties_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .sum       (sum)
);

/* bench/prefix_adder64_tb.sv */
`timescale 1ns/1ps

module prefix_adder64_tb
  import adder_pkg::*;
();

  localparam int LATENCY       = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int DRAIN_TIMEOUT = 20;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  data_t a;
  data_t b;
  logic  out_valid;
  data_t sum;

  logic [31:0] lcg_state = 32'hc2d8;
  int unsigned cycle_cnt = 0;
  data_t       exp_q[$];    // Expected sums in flight
  int unsigned entry_q[$];  // Edge on which each word was sampled

  prefix_adder64 prefix_adder64_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .sum       (sum)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  task automatic abort_run(input string reason);
    $display("ERROR at %0t: %s", $time, reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s actual %h expected %h",
               $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic drive_word(input logic valid, input data_t op_a, input data_t op_b);
    @(posedge clk);
    in_valid <= valid;
    a        <= op_a;
    b        <= op_b;
  endtask

  task automatic drive_random(input logic valid);
    data_t       op_a;
    data_t       op_b;
    logic [31:0] mode;
    op_a = rand_word();
    mode = next_rand();
    case (mode[1:0])
      2'd0:    op_b = ~op_a;                        // Every bit propagates
      2'd1:    op_b = ~op_a + data_t'(mode[7:4]);   // Carry runs the whole word
      default: op_b = rand_word();
    endcase
    drive_word(valid, op_a, op_b);
  endtask

  // --------------------
  // Model and output checks
  // --------------------

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (!rst_n)
    begin
      if (cycle_cnt > 1)  // Flops settle on the first edge
        check_value("out_valid", 64'(out_valid), 64'd0);
    end
    else if (out_valid)
    begin
      if (exp_q.size() == 0)
        abort_run("out_valid high with no word in flight");
      else
      begin
        check_value("sum", sum, exp_q[0]);
        check_value("latency", 64'(cycle_cnt - entry_q[0]), 64'(LATENCY));
        void'(exp_q.pop_front());
        void'(entry_q.pop_front());
      end
    end
    else if (exp_q.size() != 0 && cycle_cnt - entry_q[0] >= LATENCY)
      abort_run("out_valid stayed low for a word that was due");

    if (rst_n && in_valid)
    begin
      exp_q.push_back(a + b);  // Wraps modulo 2^64
      entry_q.push_back(cycle_cnt);
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  initial
  begin : main
    int          wait_cycles;
    logic [31:0] gap;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) drive_word(1'b0, '0, '0);  // Idle, nothing may come out

    drive_word(1'b1, '1, 64'd1);  // Wraps to zero
    drive_word(1'b1, 64'h0000_0000_000f_f000, 64'h0000_0000_0000_1000);  // Group 3/4
    drive_word(1'b1, 64'h0000_00ff_ff00_0000, 64'h0000_0000_0100_0000);  // Block 1/2
    drive_word(1'b1, '1, '1);
    drive_word(1'b1, '0, '0);
    drive_word(1'b1, 64'h0000_ffff_ffff_ffff, 64'd1);  // Across three blocks
    drive_word(1'b0, '0, '0);

    repeat (200) drive_random(1'b1);  // Full pipeline

    repeat (300)
    begin
      gap = next_rand();
      drive_random(gap[5]);  // Random holes in the strobe
    end
    drive_word(1'b0, '0, '0);

    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_q.size() != 0)
      abort_run("timeout while waiting for the pipeline to drain");
    else
    begin
      repeat (8) @(posedge clk);  // Any stray output is caught here
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* verilog.f */
source/adder_pkg.sv
source/adder_pg_stage.sv
source/adder_group_stage.sv
source/adder_block_stage.sv
source/adder_sum_stage.sv
source/prefix_adder64.sv
bench/prefix_adder64_properties.sv
bench/prefix_adder64_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --assert \
  --top-module prefix_adder64_tb \
  -f verilog.f \
  -o sim_prefix_adder64
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_prefix_adder64
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
